//--- verilog.f
common/cpu_pkg.sv
rtl/id_decode.sv
rtl/id_ex.sv
rtl/ex_alu.sv
rtl/pipe_ctrl.sv
rtl/id_ex_slice.sv
verification/id_ex_slice_assertions.sv
verification/tb_id_ex_slice.sv

//--- Bender.yml
package:
  name: id_ex_slice

sources:
  - common/cpu_pkg.sv
  - rtl/id_decode.sv
  - rtl/id_ex.sv
  - rtl/ex_alu.sv
  - rtl/pipe_ctrl.sv
  - rtl/id_ex_slice.sv
  - target: simulation
    files:
      - verification/id_ex_slice_assertions.sv
      - verification/tb_id_ex_slice.sv

//--- verification/tb_id_ex_slice.sv
module tb_id_ex_slice;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int          NUM_SLOTS = 400;
    localparam int          MAX_WAIT  = 40;
    localparam logic [31:0] LFSR_SEED = 32'h74831b1a;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    addr_t     pc;
    word_t     reg1_data;
    word_t     reg2_data;
    logic      stall;
    logic      flush;
    logic      fetch_adv;
    word_t     ex_wdata;
    reg_addr_t ex_wd;
    logic      ex_wreg;
    addr_t     ex_pc;
    logic      ex_ds;
    except_t   ex_except;

    // Model state
    word_t       exp_wdata;
    reg_addr_t   exp_wd;
    logic        exp_wreg;
    addr_t       exp_pc;
    logic        exp_ds;
    except_t     exp_except;
    logic        ds_pending;   // Jump accepted, slot not yet taken
    logic [31:0] lfsr_q;
    logic        timed_out;
    int          errors;
    int          accepted;
    int          flushes;
    int          total;

    id_ex_slice i_id_ex_slice (
        .clk                  (clk),
        .rst_n_i              (rst_n),
        .inst_valid_i         (inst_valid),
        .inst_i               (inst),
        .pc_i                 (pc),
        .reg1_data_i          (reg1_data),
        .reg2_data_i          (reg2_data),
        .stall_i              (stall),
        .flush_i              (flush),
        .fetch_adv_o          (fetch_adv),
        .ex_wdata_o           (ex_wdata),
        .ex_wd_o              (ex_wd),
        .ex_wreg_o            (ex_wreg),
        .ex_pc_o              (ex_pc),
        .ex_is_in_delayslot_o (ex_ds),
        .ex_except_o          (ex_except)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #200us;
        $display("Timeout: the simulation ran past its time limit");
        $display("TEST FAIL");
        $finish;
    end

    // ##################################################
    // Random numbers
    // ##################################################
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            b      = lfsr_q[0];
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? LFSR_TAPS : 32'h0);   // One step per bit
            v      = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic opcode_known(input logic [5:0] op);
        case (op)
            OP_SPECIAL, OP_ADDIU, OP_ORI, OP_LUI, OP_JAL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic funct_known(input logic [5:0] fn);
        case (fn)
            FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR: return 1'b1;
            FN_SLT, FN_SLL, FN_JR, FN_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic make_instruction();
        logic [3:0]  cls;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  code;
        cls  = 4'(rand_bits(4));
        rs   = 5'(rand_bits(5));
        rt   = 5'(rand_bits(5));
        rd   = 5'(rand_bits(5));
        sh   = 5'(rand_bits(5));
        imm  = 16'(rand_bits(16));
        code = 6'(rand_bits(6));
        case (cls)
            4'd0:  inst = {OP_SPECIAL, rs, rt, rd, sh, FN_ADDU};
            4'd1:  inst = {OP_SPECIAL, rs, rt, rd, sh, FN_SUBU};
            4'd2:  inst = {OP_SPECIAL, rs, rt, rd, sh, FN_AND};
            4'd3:  inst = {OP_SPECIAL, rs, rt, rd, sh, FN_OR};
            4'd4:  inst = {OP_SPECIAL, rs, rt, rd, sh, FN_XOR};
            4'd5:  inst = {OP_SPECIAL, rs, rt, rd, sh, FN_SLT};
            4'd6:  inst = {OP_SPECIAL, 5'd0, rt, rd, sh, FN_SLL};
            4'd7:  inst = {OP_SPECIAL, rs, 5'd0, 5'd0, 5'd0, FN_JR};
            4'd8:  inst = {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FN_JALR};
            4'd9:  inst = {OP_ADDIU, rs, rt, imm};
            4'd10: inst = {OP_ORI, rs, rt, imm};
            4'd11: inst = {OP_LUI, 5'd0, rt, imm};
            4'd12: inst = {OP_JAL, rs, rt, imm};
            4'd13, 4'd14: begin
                if (opcode_known(code)) begin
                    code = 6'b111111;
                end
                inst = {code, rs, rt, imm};   // Reserved opcode
            end
            default: begin
                if (funct_known(code)) begin
                    code = 6'b111111;
                end
                inst = {OP_SPECIAL, rs, rt, rd, sh, code};   // Reserved function
            end
        endcase
        pc        = rand_bits(30) << 2;
        reg1_data = rand_bits(32);
        reg2_data = rand_bits(32);
    endtask

    // ##################################################
    // Reference model
    // ##################################################
    task automatic predict(input inst_t in_inst, input addr_t in_pc, input word_t r1,
                           input word_t r2, output word_t wdata, output reg_addr_t wd,
                           output logic wreg, output logic rsvd, output logic jump);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        op    = in_inst[31:26];
        fn    = in_inst[5:0];
        imm   = in_inst[15:0];
        wdata = '0;
        wd    = '0;
        wreg  = 1'b0;
        rsvd  = 1'b0;
        jump  = 1'b0;
        case (op)
            OP_SPECIAL: begin
                wd   = in_inst[15:11];
                wreg = 1'b1;
                case (fn)
                    FN_ADDU: wdata = r1 + r2;
                    FN_SUBU: wdata = r1 - r2;
                    FN_AND:  wdata = r1 & r2;
                    FN_OR:   wdata = r1 | r2;
                    FN_XOR:  wdata = r1 ^ r2;
                    FN_SLT:  wdata = ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
                    FN_SLL:  wdata = r2 << in_inst[10:6];
                    FN_JR: begin
                        wd   = '0;
                        wreg = 1'b0;
                        jump = 1'b1;
                    end
                    FN_JALR: begin
                        wdata = in_pc + 32'd8;
                        jump  = 1'b1;
                    end
                    default: begin
                        wd   = '0;
                        wreg = 1'b0;
                        rsvd = 1'b1;
                    end
                endcase
            end
            OP_ADDIU: begin
                wdata = r1 + {{16{imm[15]}}, imm};
                wd    = in_inst[20:16];
                wreg  = 1'b1;
            end
            OP_ORI: begin
                wdata = r1 | {16'h0000, imm};
                wd    = in_inst[20:16];
                wreg  = 1'b1;
            end
            OP_LUI: begin
                wdata = {imm, 16'h0000};
                wd    = in_inst[20:16];
                wreg  = 1'b1;
            end
            OP_JAL: begin
                wdata = in_pc + 32'd8;
                wd    = 5'd31;
                wreg  = 1'b1;
                jump  = 1'b1;
            end
            default: rsvd = 1'b1;
        endcase
        if (wd == 5'd0) begin
            wreg = 1'b0;   // r0 is never written
        end
    endtask

    task automatic clear_model();
        exp_wdata  = '0;
        exp_wd     = '0;
        exp_wreg   = 1'b0;
        exp_pc     = '0;
        exp_ds     = 1'b0;
        exp_except = '0;
        ds_pending = 1'b0;
    endtask

    task automatic update_model();
        logic rsvd;
        logic jump;
        if (flush) begin
            clear_model();
            flushes++;
        end else if (!stall) begin
            if (inst_valid) begin
                predict(inst, pc, reg1_data, reg2_data, exp_wdata, exp_wd, exp_wreg, rsvd, jump);
                exp_except = {31'd0, rsvd};
                exp_ds     = ds_pending;
                ds_pending = jump;
                accepted++;
            end else begin
                exp_wdata  = '0;   // Bubble
                exp_wd     = '0;
                exp_wreg   = 1'b0;
                exp_except = '0;
                exp_ds     = ds_pending;
            end
            exp_pc = pc;
        end
    endtask

    // ##################################################
    // Checks and cycles
    // ##################################################
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_outputs();
        check_value("ex_wdata_o", exp_wdata, ex_wdata);
        check_value("ex_wd_o", 32'(exp_wd), 32'(ex_wd));
        check_value("ex_wreg_o", 32'(exp_wreg), 32'(ex_wreg));
        check_value("ex_pc_o", exp_pc, ex_pc);
        check_value("ex_is_in_delayslot_o", 32'(exp_ds), 32'(ex_ds));
        check_value("ex_except_o", exp_except, ex_except);
    endtask

    task automatic run_cycle(output logic adv);
        logic [102:0] held;
        @(negedge clk);
        adv  = fetch_adv;
        held = {ex_wdata, ex_wd, ex_wreg, ex_pc, ex_ds, ex_except};
        check_value("fetch_adv_o", 32'(inst_valid & ~stall), 32'(fetch_adv));
        @(posedge clk);
        update_model();
        #1;
        compare_outputs();
        if (stall && !flush) begin
            assert (held === {ex_wdata, ex_wd, ex_wreg, ex_pc, ex_ds, ex_except}) else begin
                errors++;
                $display("Stall hold failed at %0d ns: ex outputs changed during a stall", $time);
            end
        end
        #1;
    endtask

    task automatic present_slot();
        logic adv;
        logic done;
        int   waited;
        make_instruction();
        inst_valid = (rand_bits(2) != 0);
        done       = 1'b0;
        waited     = 0;
        while (!done) begin
            stall = (rand_bits(2) == 0);
            flush = (rand_bits(4) == 0);
            run_cycle(adv);
            if (!inst_valid || adv) begin
                done = 1'b1;
            end else begin
                waited++;
                if (waited > MAX_WAIT) begin
                    errors++;
                    timed_out = 1'b1;
                    $display("Timeout: fetch_adv_o stayed low for %0d cycles on a held instruction",
                             waited);
                    done = 1'b1;
                end
            end
        end
    endtask

    initial begin
        lfsr_q     = LFSR_SEED;
        timed_out  = 1'b0;
        errors     = 0;
        accepted   = 0;
        flushes    = 0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        reg1_data  = '0;
        reg2_data  = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        clear_model();
        compare_outputs();   // State right after reset
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < NUM_SLOTS && !timed_out; n++) begin
            present_slot();
        end
        total = errors + i_id_ex_slice.i_id_ex.i_id_ex_assertions.fail_count;
        $display("Errors: %0d model, %0d assertion; %0d accepted, %0d flushes",
                 errors, i_id_ex_slice.i_id_ex.i_id_ex_assertions.fail_count, accepted, flushes);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verification/id_ex_slice_assertions.sv
module id_ex_slice_assertions (
    input logic               clk,
    input logic               rst_n_i,
    input logic               en_i,
    input logic               flush_i,
    input cpu_pkg::word_t     ex_reg1_o,
    input cpu_pkg::word_t     ex_reg2_o,
    input cpu_pkg::reg_addr_t ex_wd_o,
    input logic               ex_wreg_o,
    input cpu_pkg::addr_t     ex_pc_o,
    input logic               ex_is_in_delayslot_o,
    input cpu_pkg::except_t   ex_except_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    int fail_count = 0;

    // ##################################################
    // Flush, hold and exception rules
    // ##################################################
    assert property (@(posedge clk) (!rst_n_i || flush_i) |=> !ex_wreg_o)
        else begin
            fail_count++;
            $error("ID/EX write enable is set after a flush or reset");
        end

    assert property (@(posedge clk) (rst_n_i && !en_i && !flush_i) |=>
                     $stable({ex_reg1_o, ex_reg2_o, ex_wd_o, ex_wreg_o, ex_pc_o,
                              ex_is_in_delayslot_o, ex_except_o}))
        else begin
            fail_count++;
            $error("ID/EX outputs changed while the stage was disabled");
        end

    assert property (@(posedge clk) ex_except_o[EXC_RI_BIT] |-> !ex_wreg_o)   // RI never writes
        else begin
            fail_count++;
            $error("ID/EX write enable is set on a reserved instruction");
        end

endmodule

bind id_ex id_ex_slice_assertions i_id_ex_assertions (.*);

//--- rtl/id_ex_slice.sv
module id_ex_slice (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  cpu_pkg::inst_t      inst_i,
    input  cpu_pkg::addr_t      pc_i,
    input  cpu_pkg::word_t      reg1_data_i,
    input  cpu_pkg::word_t      reg2_data_i,
    input  logic                stall_i,
    input  logic                flush_i,
    output logic                fetch_adv_o,
    output cpu_pkg::word_t      ex_wdata_o,
    output cpu_pkg::reg_addr_t  ex_wd_o,
    output logic                ex_wreg_o,
    output cpu_pkg::addr_t      ex_pc_o,
    output logic                ex_is_in_delayslot_o,
    output cpu_pkg::except_t    ex_except_o
);
    import cpu_pkg::*;

    logic      stage_en;
    logic      fetch_adv;
    logic      is_in_delayslot;   // Fed back from ID/EX

    // Decode side
    alu_op_t   id_aluop;
    alu_sel_t  id_alusel;
    word_t     id_reg1;
    word_t     id_reg2;
    reg_addr_t id_wd;
    logic      id_wreg;
    inst_t     id_inst;
    addr_t     id_pc;
    word_t     id_link_addr;
    logic      id_is_in_delayslot;
    logic      next_in_delayslot;
    except_t   id_except;

    // Execute side
    alu_op_t   ex_aluop;
    alu_sel_t  ex_alusel;
    word_t     ex_reg1;
    word_t     ex_reg2;
    reg_addr_t ex_wd;
    logic      ex_wreg;
    inst_t     ex_inst;
    word_t     ex_link_addr;

    assign fetch_adv_o = fetch_adv;

    pipe_ctrl i_pipe_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .stage_en_o   (stage_en),
        .fetch_adv_o  (fetch_adv)
    );

    id_decode i_id_decode (
        .inst_valid_i        (inst_valid_i),
        .inst_i              (inst_i),
        .pc_i                (pc_i),
        .reg1_data_i         (reg1_data_i),
        .reg2_data_i         (reg2_data_i),
        .is_in_delayslot_i   (is_in_delayslot),
        .aluop_o             (id_aluop),
        .alusel_o            (id_alusel),
        .reg1_o              (id_reg1),
        .reg2_o              (id_reg2),
        .wd_o                (id_wd),
        .wreg_o              (id_wreg),
        .inst_o              (id_inst),
        .pc_o                (id_pc),
        .link_addr_o         (id_link_addr),
        .is_in_delayslot_o   (id_is_in_delayslot),
        .next_in_delayslot_o (next_in_delayslot),
        .except_o            (id_except)
    );

    id_ex i_id_ex (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .en_i                 (stage_en),
        .en_pc_i              (fetch_adv),
        .flush_i              (flush_i),
        .id_aluop_i           (id_aluop),
        .id_alusel_i          (id_alusel),
        .id_reg1_i            (id_reg1),
        .id_reg2_i            (id_reg2),
        .id_wd_i              (id_wd),
        .id_wreg_i            (id_wreg),
        .id_inst_i            (id_inst),
        .id_pc_i              (id_pc),
        .id_link_addr_i       (id_link_addr),
        .id_is_in_delayslot_i (id_is_in_delayslot),
        .id_except_i          (id_except),
        .next_in_delayslot_i  (next_in_delayslot),
        .ex_aluop_o           (ex_aluop),
        .ex_alusel_o          (ex_alusel),
        .ex_reg1_o            (ex_reg1),
        .ex_reg2_o            (ex_reg2),
        .ex_wd_o              (ex_wd),
        .ex_wreg_o            (ex_wreg),
        .ex_inst_o            (ex_inst),
        .ex_pc_o              (ex_pc_o),
        .ex_link_addr_o       (ex_link_addr),
        .ex_is_in_delayslot_o (ex_is_in_delayslot_o),
        .ex_except_o          (ex_except_o),
        .is_in_delayslot_o    (is_in_delayslot)
    );

    ex_alu i_ex_alu (
        .aluop_i     (ex_aluop),
        .alusel_i    (ex_alusel),
        .reg1_i      (ex_reg1),
        .reg2_i      (ex_reg2),
        .inst_i      (ex_inst),
        .link_addr_i (ex_link_addr),
        .wd_i        (ex_wd),
        .wreg_i      (ex_wreg),
        .wdata_o     (ex_wdata_o),
        .wd_o        (ex_wd_o),
        .wreg_o      (ex_wreg_o)
    );

endmodule

//--- rtl/pipe_ctrl.sv
module pipe_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic inst_valid_i,
    input  logic stall_i,
    input  logic flush_i,
    output logic stage_en_o,
    output logic fetch_adv_o
);

    // ##################################################
    // Strobes
    // ##################################################
    assign stage_en_o  = ~stall_i;
    assign fetch_adv_o = inst_valid_i & ~stall_i;   // Held instruction may advance

endmodule

//--- rtl/ex_alu.sv
module ex_alu (
    input  cpu_pkg::alu_op_t    aluop_i,
    input  cpu_pkg::alu_sel_t   alusel_i,
    input  cpu_pkg::word_t      reg1_i,
    input  cpu_pkg::word_t      reg2_i,
    input  cpu_pkg::inst_t      inst_i,
    input  cpu_pkg::word_t      link_addr_i,
    input  cpu_pkg::reg_addr_t  wd_i,
    input  logic                wreg_i,
    output cpu_pkg::word_t      wdata_o,
    output cpu_pkg::reg_addr_t  wd_o,
    output logic                wreg_o
);
    import cpu_pkg::*;

    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    logic [4:0] shamt;
    logic       lt;

    assign shamt = inst_i[10:6];
    assign lt    = $signed(reg1_i) < $signed(reg2_i);

    // ##################################################
    // Per-class results
    // ##################################################
    always_comb begin
        case (aluop_i)
            ALU_AND: logic_res = reg1_i & reg2_i;
            ALU_OR:  logic_res = reg1_i | reg2_i;
            ALU_XOR: logic_res = reg1_i ^ reg2_i;
            ALU_LUI: logic_res = reg2_i;   // Already shifted by decode
            default: logic_res = ZERO_WORD;
        endcase
    end

    always_comb begin
        if (aluop_i == ALU_SLL) begin
            shift_res = reg2_i << shamt;
        end else begin
            shift_res = ZERO_WORD;
        end
    end

    always_comb begin
        case (aluop_i)
            ALU_ADDU: arith_res = reg1_i + reg2_i;
            ALU_SUBU: arith_res = reg1_i - reg2_i;
            ALU_SLT:  arith_res = {31'd0, lt};   // Signed compare
            default:  arith_res = ZERO_WORD;
        endcase
    end

    // ##################################################
    // Result select
    // ##################################################
    always_comb begin
        case (alusel_i)
            SEL_LOGIC: wdata_o = logic_res;
            SEL_SHIFT: wdata_o = shift_res;
            SEL_ARITH: wdata_o = arith_res;
            SEL_JUMP:  wdata_o = link_addr_i;
            default:   wdata_o = ZERO_WORD;
        endcase
    end

    assign wd_o   = wd_i;
    assign wreg_o = wreg_i && (wd_i != NOP_REG_ADDR);   // r0 never written

endmodule

//--- rtl/id_ex.sv
module id_ex (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                en_i,
    input  logic                en_pc_i,
    input  logic                flush_i,
    input  cpu_pkg::alu_op_t    id_aluop_i,
    input  cpu_pkg::alu_sel_t   id_alusel_i,
    input  cpu_pkg::word_t      id_reg1_i,
    input  cpu_pkg::word_t      id_reg2_i,
    input  cpu_pkg::reg_addr_t  id_wd_i,
    input  logic                id_wreg_i,
    input  cpu_pkg::inst_t      id_inst_i,
    input  cpu_pkg::addr_t      id_pc_i,
    input  cpu_pkg::word_t      id_link_addr_i,
    input  logic                id_is_in_delayslot_i,
    input  cpu_pkg::except_t    id_except_i,
    input  logic                next_in_delayslot_i,
    output cpu_pkg::alu_op_t    ex_aluop_o,
    output cpu_pkg::alu_sel_t   ex_alusel_o,
    output cpu_pkg::word_t      ex_reg1_o,
    output cpu_pkg::word_t      ex_reg2_o,
    output cpu_pkg::reg_addr_t  ex_wd_o,
    output logic                ex_wreg_o,
    output cpu_pkg::inst_t      ex_inst_o,
    output cpu_pkg::addr_t      ex_pc_o,
    output cpu_pkg::word_t      ex_link_addr_o,
    output logic                ex_is_in_delayslot_o,
    output cpu_pkg::except_t    ex_except_o,
    output logic                is_in_delayslot_o
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex_aluop_o           <= ALU_NOP;
            ex_alusel_o          <= SEL_NOP;
            ex_reg1_o            <= ZERO_WORD;
            ex_reg2_o            <= ZERO_WORD;
            ex_wd_o              <= NOP_REG_ADDR;
            ex_wreg_o            <= 1'b0;
            ex_inst_o            <= '0;
            ex_pc_o              <= '0;
            ex_link_addr_o       <= ZERO_WORD;
            ex_is_in_delayslot_o <= 1'b0;
            ex_except_o          <= '0;
        end else if (en_i) begin
            ex_aluop_o           <= id_aluop_i;
            ex_alusel_o          <= id_alusel_i;
            ex_reg1_o            <= id_reg1_i;
            ex_reg2_o            <= id_reg2_i;
            ex_wd_o              <= id_wd_i;
            ex_wreg_o            <= id_wreg_i;
            ex_inst_o            <= id_inst_i;
            ex_pc_o              <= id_pc_i;
            ex_link_addr_o       <= id_link_addr_i;
            ex_is_in_delayslot_o <= id_is_in_delayslot_i;
            ex_except_o          <= id_except_i;
        end
    end

    // ##################################################
    // Delay slot tracking
    // ##################################################
    // Fetch lies outside the slice, so the acceptance strobe itself is the
    // one-deep history that releases the flag
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            is_in_delayslot_o <= 1'b0;
        end else if (en_pc_i) begin
            is_in_delayslot_o <= next_in_delayslot_i;   // Release
        end
    end

endmodule

//--- rtl/id_decode.sv
module id_decode (
    input  logic                inst_valid_i,
    input  cpu_pkg::inst_t      inst_i,
    input  cpu_pkg::addr_t      pc_i,
    input  cpu_pkg::word_t      reg1_data_i,
    input  cpu_pkg::word_t      reg2_data_i,
    input  logic                is_in_delayslot_i,
    output cpu_pkg::alu_op_t    aluop_o,
    output cpu_pkg::alu_sel_t   alusel_o,
    output cpu_pkg::word_t      reg1_o,
    output cpu_pkg::word_t      reg2_o,
    output cpu_pkg::reg_addr_t  wd_o,
    output logic                wreg_o,
    output cpu_pkg::inst_t      inst_o,
    output cpu_pkg::addr_t      pc_o,
    output cpu_pkg::word_t      link_addr_o,
    output logic                is_in_delayslot_o,
    output logic                next_in_delayslot_o,
    output cpu_pkg::except_t    except_o
);
    import cpu_pkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [15:0] imm;
    word_t      pc_plus8;

    assign op       = inst_i[31:26];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign funct    = inst_i[5:0];
    assign imm      = inst_i[15:0];
    assign pc_plus8 = pc_i + 32'd8;   // Past the delay slot

    assign inst_o            = inst_i;
    assign pc_o              = pc_i;
    assign is_in_delayslot_o = is_in_delayslot_i;

    always_comb begin
        aluop_o             = ALU_NOP;
        alusel_o            = SEL_NOP;
        reg1_o              = ZERO_WORD;
        reg2_o              = ZERO_WORD;
        wd_o                = NOP_REG_ADDR;
        wreg_o              = 1'b0;
        link_addr_o         = ZERO_WORD;
        next_in_delayslot_o = 1'b0;
        except_o            = '0;
        if (inst_valid_i) begin   // Invalid cycle stays a bubble
            reg1_o = reg1_data_i;
            case (op)
                OP_SPECIAL: begin
                    reg2_o = reg2_data_i;
                    wd_o   = rd;
                    wreg_o = 1'b1;
                    case (funct)
                        FN_ADDU: {aluop_o, alusel_o} = {ALU_ADDU, SEL_ARITH};
                        FN_SUBU: {aluop_o, alusel_o} = {ALU_SUBU, SEL_ARITH};
                        FN_AND:  {aluop_o, alusel_o} = {ALU_AND, SEL_LOGIC};
                        FN_OR:   {aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
                        FN_XOR:  {aluop_o, alusel_o} = {ALU_XOR, SEL_LOGIC};
                        FN_SLT:  {aluop_o, alusel_o} = {ALU_SLT, SEL_ARITH};
                        FN_SLL:  {aluop_o, alusel_o} = {ALU_SLL, SEL_SHIFT};
                        FN_JR: begin
                            wd_o                = NOP_REG_ADDR;
                            wreg_o              = 1'b0;   // Target resolved elsewhere
                            next_in_delayslot_o = 1'b1;
                        end
                        FN_JALR: begin
                            {aluop_o, alusel_o} = {ALU_JAL, SEL_JUMP};
                            link_addr_o         = pc_plus8;
                            next_in_delayslot_o = 1'b1;
                        end
                        default: begin
                            wd_o                  = NOP_REG_ADDR;
                            wreg_o                = 1'b0;
                            except_o[EXC_RI_BIT]  = 1'b1;
                        end
                    endcase
                end
                OP_ADDIU: begin
                    {aluop_o, alusel_o} = {ALU_ADDU, SEL_ARITH};
                    reg2_o = {{16{imm[15]}}, imm};   // Sign extended
                    wd_o   = rt;
                    wreg_o = 1'b1;
                end
                OP_ORI: begin
                    {aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
                    reg2_o = {16'h0000, imm};
                    wd_o   = rt;
                    wreg_o = 1'b1;
                end
                OP_LUI: begin
                    {aluop_o, alusel_o} = {ALU_LUI, SEL_LOGIC};
                    reg2_o = {imm, 16'h0000};
                    wd_o   = rt;
                    wreg_o = 1'b1;
                end
                OP_JAL: begin
                    {aluop_o, alusel_o} = {ALU_JAL, SEL_JUMP};
                    wd_o                = LINK_REG;
                    wreg_o              = 1'b1;
                    link_addr_o         = pc_plus8;
                    next_in_delayslot_o = 1'b1;
                end
                default: except_o[EXC_RI_BIT] = 1'b1;   // Reserved instruction
            endcase
        end
    end

endmodule

//--- common/cpu_pkg.sv
package cpu_pkg;

    // ##################################################
    // Widths
    // ##################################################
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] except_t;   // Bit 0 reserved instruction

    // ##################################################
    // Operation and result select
    // ##################################################
    typedef enum logic [7:0] {
        ALU_NOP  = 8'b0000_0000,
        ALU_ADDU = 8'b0010_0001,
        ALU_SUBU = 8'b0010_0011,
        ALU_AND  = 8'b0010_0100,
        ALU_OR   = 8'b0010_0101,
        ALU_XOR  = 8'b0010_0110,
        ALU_SLT  = 8'b0010_1010,
        ALU_SLL  = 8'b0111_1100,
        ALU_LUI  = 8'b0101_1100,
        ALU_JAL  = 8'b0101_0000    // Link write for JAL/JALR
    } alu_op_t;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100,
        SEL_JUMP  = 3'b110
    } alu_sel_t;

    typedef enum logic {
        RUN   = 1'b0,
        STALL = 1'b1
    } ctrl_state_t;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_JAL     = 6'b000011;

    // SPECIAL function codes
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;

    localparam reg_addr_t NOP_REG_ADDR = 5'd0;
    localparam reg_addr_t LINK_REG     = 5'd31;
    localparam word_t     ZERO_WORD    = 32'h0000_0000;
    localparam int        EXC_RI_BIT   = 0;

endpackage
